// ==== build.f ====
+incdir+verilog
verilog/rv_pkg.sv
verilog/fetch_decode.sv
verilog/register_file.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/commit_stage.sv
verilog/cpu.sv
bench/cpu_tb.sv

// ==== run.sh ====
#!/bin/bash
# build the cpu testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module cpu_tb -o cpu_sim \
  && ./obj_dir/cpu_sim | tee /dev/stderr | grep -q "^Regression passed$" \
  && exit 0 \
  || exit 1

// ==== bench/cpu_tb.sv ====
`default_nettype none
`include "rv_cfg.svh"

module cpu_tb;

  localparam logic [31:0] FINAL_PC = 32'd100;
  localparam int TIMEOUT_CYCLES = 200;

  logic        clk;
  logic        rst;
  logic        prog_we;
  logic [4:0]  prog_addr;
  logic [31:0] prog_data;
  wire  [31:0] pc;
  wire         wb_en;
  wire  [4:0]  wb_addr;
  wire  [31:0] wb_data;
  wire         store_en;
  wire  [31:0] store_addr;
  wire  [31:0] store_data;

  integer      seed;
  integer      errors;
  logic        started = 1'b0;
  logic [31:0] prog [`RV_IMEM_WORDS];

  // reference model state
  logic [31:0] m_pc;
  logic [31:0] m_regs [32];
  logic [31:0] m_dmem [`RV_DMEM_WORDS];
  logic [31:0] m_instr;
  logic [31:0] m_a;
  logic [31:0] m_b;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] ea;
  logic [2:0]  f3;
  logic        exp_wb_en;
  logic [31:0] exp_wb_data;
  logic        exp_store_en;
  logic [31:0] exp_store_addr;
  logic [31:0] exp_store_data;
  logic [31:0] exp_next_pc;

  cpu i_cpu (
    .clk        (clk),
    .rst        (rst),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .pc         (pc),
    .wb_en      (wb_en),
    .wb_addr    (wb_addr),
    .wb_data    (wb_data),
    .store_en   (store_en),
    .store_addr (store_addr),
    .store_data (store_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] fn,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, fn, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] fn, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, fn, rd, opc};
  endfunction

  function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch_word(input logic [12:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] fn);
    return {imm[12], imm[10:5], rs2, rs1, fn, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_word(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [11:0] rand_imm12();
    integer r;
    r = $random(seed);
    return r[11:0];
  endfunction

  // ISA result of the register and immediate ALU forms
  function automatic logic [31:0] alu_ref(input logic [2:0] fn, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    case (fn)
      3'b000: res = alt ? a - b : a + b;
      3'b001: res = a << b[4:0];
      3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100: res = a ^ b;
      3'b101: begin
        if (alt) begin
          res = $signed(a) >>> b[4:0];
        end else begin
          res = a >> b[4:0];
        end
      end
      3'b110: res = a | b;
      3'b111: res = a & b;
      default: res = 32'd0;
    endcase
    return res;
  endfunction

  task automatic build_program();
    logic [31:0] a_val;
    logic [19:0] a_hi;
    logic [4:0]  sh;
    logic [11:0] imm12;
    integer      r;
    // x1 negative, x2 small positive, so slt differs from an unsigned compare
    r     = $random(seed);
    a_val = r | 32'h8000_0000;
    a_hi  = 20'((a_val + 32'h800) >> 12);
    r     = $random(seed);
    // nonzero so srai shows the sign fill
    sh    = r[4:0] | 5'd1;
    imm12 = rand_imm12();
    prog[0]  = {a_hi, 5'd1, 7'b0110111};
    prog[1]  = i_type(a_val[11:0], 5'd1, 3'b000, 5'd1, 7'b0010011);
    prog[2]  = i_type({1'b0, imm12[10:0]}, 5'd0, 3'b000, 5'd2, 7'b0010011);
    prog[3]  = r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3);
    prog[4]  = r_type(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd4);
    prog[5]  = r_type(7'b0000000, 5'd2, 5'd1, 3'b111, 5'd5);
    prog[6]  = r_type(7'b0000000, 5'd2, 5'd1, 3'b110, 5'd6);
    prog[7]  = r_type(7'b0000000, 5'd2, 5'd1, 3'b100, 5'd7);
    prog[8]  = r_type(7'b0000000, 5'd2, 5'd1, 3'b001, 5'd8);
    prog[9]  = r_type(7'b0000000, 5'd2, 5'd1, 3'b101, 5'd9);
    prog[10] = r_type(7'b0100000, 5'd2, 5'd1, 3'b101, 5'd10);
    prog[11] = r_type(7'b0000000, 5'd2, 5'd1, 3'b010, 5'd11);
    prog[12] = i_type(rand_imm12(), 5'd1, 3'b000, 5'd12, 7'b0010011);
    prog[13] = i_type(rand_imm12(), 5'd1, 3'b111, 5'd13, 7'b0010011);
    prog[14] = i_type(rand_imm12(), 5'd1, 3'b110, 5'd14, 7'b0010011);
    prog[15] = i_type(rand_imm12(), 5'd1, 3'b100, 5'd15, 7'b0010011);
    prog[16] = i_type({7'b0000000, sh}, 5'd1, 3'b001, 5'd16, 7'b0010011);
    prog[17] = i_type({7'b0000000, sh}, 5'd1, 3'b101, 5'd17, 7'b0010011);
    prog[18] = i_type({7'b0100000, sh}, 5'd1, 3'b101, 5'd18, 7'b0010011);
    prog[19] = i_type(rand_imm12(), 5'd1, 3'b010, 5'd19, 7'b0010011);
    // write to x0, then use x0 as the store and load base
    prog[20] = i_type(12'd5, 5'd1, 3'b000, 5'd0, 7'b0010011);
    prog[21] = store_word(12'd20, 5'd3, 5'd0);
    prog[22] = i_type(12'd20, 5'd0, 3'b010, 5'd20, 7'b0000011);
    prog[23] = branch_word(13'd8, 5'd2, 5'd1, 3'b000);
    prog[24] = branch_word(13'd8, 5'd1, 5'd1, 3'b000);
    // final self-jump, skipped now and reached through jalr
    prog[25] = jal_word(21'd0, 5'd0);
    prog[26] = branch_word(13'd8, 5'd1, 5'd1, 3'b001);
    prog[27] = branch_word(13'd8, 5'd2, 5'd1, 3'b001);
    prog[28] = i_type(12'd1, 5'd0, 3'b000, 5'd22, 7'b0010011);
    prog[29] = jal_word(21'd8, 5'd21);
    prog[30] = i_type(12'd1, 5'd0, 3'b000, 5'd23, 7'b0010011);
    // odd sum, bit 0 gets cleared
    prog[31] = i_type(12'd101, 5'd0, 3'b000, 5'd22, 7'b1100111);
  endtask

  always_comb begin
    m_instr = prog[m_pc[6:2]];
    f3      = m_instr[14:12];
    m_a     = m_regs[m_instr[19:15]];
    m_b     = m_regs[m_instr[24:20]];
    imm_i   = {{20{m_instr[31]}}, m_instr[31:20]};
    imm_s   = {{20{m_instr[31]}}, m_instr[31:25], m_instr[11:7]};
    imm_b   = {{19{m_instr[31]}}, m_instr[31], m_instr[7], m_instr[30:25], m_instr[11:8], 1'b0};
    imm_j   = {{11{m_instr[31]}}, m_instr[31], m_instr[19:12], m_instr[20], m_instr[30:21],
               1'b0};
    ea      = m_a + imm_i;
    exp_wb_en      = 1'b0;
    exp_wb_data    = 32'd0;
    exp_store_en   = 1'b0;
    exp_store_addr = m_a + imm_s;
    exp_store_data = m_b;
    exp_next_pc    = m_pc + 32'd4;
    case (m_instr[6:0])
      7'b0110011: begin
        exp_wb_en   = (f3 != 3'b011);
        exp_wb_data = alu_ref(f3, m_instr[30], m_a, m_b);
      end
      7'b0010011: begin
        exp_wb_en   = (f3 != 3'b011);
        exp_wb_data = alu_ref(f3, m_instr[30] && f3 == 3'b101, m_a, imm_i);
      end
      7'b0110111: begin
        exp_wb_en   = 1'b1;
        exp_wb_data = {m_instr[31:12], 12'd0};
      end
      7'b0000011: begin
        exp_wb_en   = 1'b1;
        exp_wb_data = m_dmem[ea[6:2]];
      end
      7'b0100011: exp_store_en = 1'b1;
      7'b1101111: begin
        exp_wb_en   = 1'b1;
        exp_wb_data = m_pc + 32'd4;
        exp_next_pc = m_pc + imm_j;
      end
      7'b1100111: begin
        exp_wb_en   = 1'b1;
        exp_wb_data = m_pc + 32'd4;
        exp_next_pc = ea & ~32'd1;
      end
      7'b1100011: begin
        if ((f3 == 3'b000 && m_a == m_b) || (f3 == 3'b001 && m_a != m_b)) begin
          exp_next_pc = m_pc + imm_b;
        end
      end
      default: ;
    endcase
    if (rst) begin
      exp_wb_en    = 1'b0;
      exp_store_en = 1'b0;
    end
  end

  always @(posedge clk) begin
    started <= 1'b1;
    if (rst) begin
      m_pc <= `RV_RESET_PC;
      for (int i = 0; i < 32; i++) begin
        m_regs[i] <= 32'd0;
      end
    end else begin
      m_pc <= exp_next_pc;
      if (exp_wb_en && m_instr[11:7] != 5'd0) begin
        m_regs[m_instr[11:7]] <= exp_wb_data;
      end
      if (exp_store_en) begin
        m_dmem[exp_store_addr[6:2]] <= exp_store_data;
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    errors++;
    $display("ERROR %s at %0t: expected %h, got %h", name, $time, exp, got);
  endtask

  assert property (@(posedge clk) started && rst |-> pc == `RV_RESET_PC)
    else report_mismatch("pc", `RV_RESET_PC, $sampled(pc));
  assert property (@(posedge clk) started |-> pc == m_pc)
    else report_mismatch("pc", $sampled(m_pc), $sampled(pc));
  assert property (@(posedge clk) started |-> wb_en == exp_wb_en)
    else report_mismatch("wb_en", 32'($sampled(exp_wb_en)), 32'($sampled(wb_en)));
  assert property (@(posedge clk) started && exp_wb_en |-> wb_addr == m_instr[11:7])
    else report_mismatch("wb_addr", 32'($sampled(m_instr[11:7])), 32'($sampled(wb_addr)));
  assert property (@(posedge clk) started && exp_wb_en |-> wb_data == exp_wb_data)
    else report_mismatch("wb_data", $sampled(exp_wb_data), $sampled(wb_data));
  assert property (@(posedge clk) started |-> store_en == exp_store_en)
    else report_mismatch("store_en", 32'($sampled(exp_store_en)), 32'($sampled(store_en)));
  assert property (@(posedge clk) started && exp_store_en |-> store_addr == exp_store_addr)
    else report_mismatch("store_addr", $sampled(exp_store_addr), $sampled(store_addr));
  assert property (@(posedge clk) started && exp_store_en |-> store_data == exp_store_data)
    else report_mismatch("store_data", $sampled(exp_store_data), $sampled(store_data));

  initial begin
    int cycles;
    rst       = 1'b1;
    prog_we   = 1'b0;
    prog_addr = 5'd0;
    prog_data = 32'd0;
    errors    = 0;
    seed      = 97259;
    build_program();
    // load with the core held in reset
    for (int i = 0; i < `RV_IMEM_WORDS; i++) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= 5'(i);
      prog_data <= prog[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    cycles = 0;
    while (pc !== FINAL_PC && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (pc !== FINAL_PC) begin
      errors++;
      $display("timeout: pc did not reach the final self-jump in %0d cycles", TIMEOUT_CYCLES);
    end
    // a few turns of the self-jump
    repeat (4) @(negedge clk);
    $display("checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/cpu.sv ====
`default_nettype none
`include "rv_cfg.svh"

module cpu (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              prog_we,
  input  wire [$clog2(`RV_IMEM_WORDS)-1:0] prog_addr,
  input  wire [31:0]                       prog_data,
  output logic [`RV_XLEN-1:0]              pc,
  output logic                             wb_en,
  output logic [4:0]                       wb_addr,
  output logic [`RV_XLEN-1:0]              wb_data,
  output logic                             store_en,
  output logic [`RV_XLEN-1:0]              store_addr,
  output logic [`RV_XLEN-1:0]              store_data
);

  rv_pkg::opcode_e     opcode;
  rv_pkg::alu_op_e     alu_op;
  rv_pkg::wb_sel_e     wb_sel;
  logic [4:0]          rs1;
  logic [4:0]          rs2;
  logic [`RV_XLEN-1:0] imm;
  logic                use_imm;
  logic                branch_ne;
  logic                reg_we;
  logic                mem_we;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] target;
  logic [`RV_XLEN-1:0] link;
  logic                taken;

  // rd goes straight out as the trace write address
  fetch_decode i_fetch_decode (
    .clk       (clk),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .pc        (pc),
    .opcode    (opcode),
    .rd        (wb_addr),
    .rs1       (rs1),
    .rs2       (rs2),
    .imm       (imm),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .branch_ne (branch_ne),
    .wb_sel    (wb_sel),
    .reg_we    (reg_we),
    .mem_we    (mem_we)
  );

  register_file i_register_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (wb_addr),
    .we       (wb_en),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu i_alu (
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .use_imm  (use_imm),
    .alu_op   (alu_op),
    .result   (alu_result)
  );

  branch_unit i_branch_unit (
    .pc        (pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .imm       (imm),
    .opcode    (opcode),
    .branch_ne (branch_ne),
    .target    (target),
    .link      (link),
    .taken     (taken)
  );

  commit_stage i_commit_stage (
    .clk        (clk),
    .rst        (rst),
    .taken      (taken),
    .target     (target),
    .link       (link),
    .alu_result (alu_result),
    .rs2_data   (rs2_data),
    .mem_we     (mem_we),
    .reg_we     (reg_we),
    .wb_sel     (wb_sel),
    .pc         (pc),
    .wb_en      (wb_en),
    .wb_data    (wb_data),
    .store_en   (store_en),
    .store_addr (store_addr),
    .store_data (store_data)
  );

endmodule

`default_nettype wire

// ==== verilog/commit_stage.sv ====
`default_nettype none
`include "rv_cfg.svh"

module commit_stage (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  taken,
  input  wire [`RV_XLEN-1:0]   target,
  input  wire [`RV_XLEN-1:0]   link,
  input  wire [`RV_XLEN-1:0]   alu_result,
  input  wire [`RV_XLEN-1:0]   rs2_data,
  input  wire                  mem_we,
  input  wire                  reg_we,
  input  wire rv_pkg::wb_sel_e wb_sel,
  output logic [`RV_XLEN-1:0]  pc,
  output logic                 wb_en,
  output logic [`RV_XLEN-1:0]  wb_data,
  output logic                 store_en,
  output logic [`RV_XLEN-1:0]  store_addr,
  output logic [`RV_XLEN-1:0]  store_data
);

  localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

  logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];
  logic [DMEM_AW-1:0]  dmem_idx;
  logic [`RV_XLEN-1:0] load_data;
  logic [`RV_XLEN-1:0] next_pc;

  // link doubles as pc + 4 when nothing is taken
  assign next_pc = taken ? target : link;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  // word addressed, low two bits ignored
  assign dmem_idx  = alu_result[DMEM_AW+1:2];
  assign load_data = dmem[dmem_idx];

  assign store_en   = mem_we & ~rst;
  assign store_addr = alu_result;
  assign store_data = rs2_data;

  always_ff @(posedge clk) begin
    if (store_en) begin
      dmem[dmem_idx] <= rs2_data;
    end
  end

  assign wb_en = reg_we & ~rst;

  always_comb begin
    case (wb_sel)
      rv_pkg::wb_load: wb_data = load_data;
      rv_pkg::wb_link: wb_data = link;
      default:         wb_data = alu_result;
    endcase
  end

  // catches misaligned jalr and branch targets
  assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc misaligned %h", pc);

endmodule

`default_nettype wire

// ==== verilog/branch_unit.sv ====
`default_nettype none
`include "rv_cfg.svh"

module branch_unit (
  input  wire [`RV_XLEN-1:0]   pc,
  input  wire [`RV_XLEN-1:0]   rs1_data,
  input  wire [`RV_XLEN-1:0]   rs2_data,
  input  wire [`RV_XLEN-1:0]   imm,
  input  wire rv_pkg::opcode_e opcode,
  input  wire                  branch_ne,
  output logic [`RV_XLEN-1:0]  target,
  output logic [`RV_XLEN-1:0]  link,
  output logic                 taken
);

  logic [`RV_XLEN-1:0] pc_rel;
  logic [`RV_XLEN-1:0] reg_rel;
  logic                equal;

  // return address and fall-through pc
  assign link = pc + `RV_XLEN'(4);

  assign pc_rel  = pc + imm;
  assign reg_rel = rs1_data + imm;
  assign equal   = (rs1_data == rs2_data);

  always_comb begin
    target = pc_rel;
    taken  = 1'b0;
    case (opcode)
      rv_pkg::op_jal: taken = 1'b1;
      rv_pkg::op_jalr: begin
        // jalr drops bit 0 of the sum
        target = {reg_rel[`RV_XLEN-1:1], 1'b0};
        taken  = 1'b1;
      end
      // beq on equal, bne on not equal
      rv_pkg::op_branch: taken = equal ^ branch_ne;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`default_nettype none
`include "rv_cfg.svh"

module alu (
  input  wire [`RV_XLEN-1:0]   rs1_data,
  input  wire [`RV_XLEN-1:0]   rs2_data,
  input  wire [`RV_XLEN-1:0]   imm,
  input  wire                  use_imm,
  input  wire rv_pkg::alu_op_e alu_op,
  output logic [`RV_XLEN-1:0]  result
);

  localparam int SHW = $clog2(`RV_XLEN);

  logic [`RV_XLEN-1:0] a;
  logic [`RV_XLEN-1:0] b;
  logic [SHW-1:0]      shamt;
  logic                less;

  assign a = rs1_data;
  // second operand is the immediate for I-type, lui and memory ops
  assign b = use_imm ? imm : rs2_data;

  // only the low bits of the operand set the shift distance
  assign shamt = b[SHW-1:0];
  assign less  = $signed(a) < $signed(b);

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add: result = a + b;
      rv_pkg::alu_sub: result = a - b;
      rv_pkg::alu_and: result = a & b;
      rv_pkg::alu_or:  result = a | b;
      rv_pkg::alu_xor: result = a ^ b;
      rv_pkg::alu_sll: result = a << shamt;
      rv_pkg::alu_srl: result = a >> shamt;
      // sign bit fills from the left
      rv_pkg::alu_sra: result = $signed(a) >>> shamt;
      rv_pkg::alu_slt: result = {{(`RV_XLEN-1){1'b0}}, less};
      default:         result = '0;
    endcase
  end

  // decode only hands over listed operations
  always_comb begin
    assert (alu_op inside {rv_pkg::alu_add, rv_pkg::alu_sub, rv_pkg::alu_and,
                           rv_pkg::alu_or, rv_pkg::alu_xor, rv_pkg::alu_sll,
                           rv_pkg::alu_srl, rv_pkg::alu_sra, rv_pkg::alu_slt})
      else $error("unknown alu_op %h", alu_op);
  end

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
`default_nettype none
`include "rv_cfg.svh"

module register_file (
  input  wire                 clk,
  input  wire                 rst,
  input  wire [4:0]           rs1,
  input  wire [4:0]           rs2,
  input  wire [4:0]           rd,
  input  wire                 we,
  input  wire [`RV_XLEN-1:0]  wdata,
  output logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  // x0 reads as zero whatever the array holds
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

  // a write aimed at x0 leaves it zero
  assert property (@(posedge clk) disable iff (rst)
    (we && rd == 5'd0) |=> regs[0] == '0)
    else $error("x0 changed to %h", regs[0]);

endmodule

`default_nettype wire

// ==== verilog/fetch_decode.sv ====
`default_nettype none
`include "rv_cfg.svh"

module fetch_decode (
  input  wire                               clk,
  input  wire                               prog_we,
  input  wire [$clog2(`RV_IMEM_WORDS)-1:0]  prog_addr,
  input  wire [31:0]                        prog_data,
  input  wire [`RV_XLEN-1:0]                pc,
  output rv_pkg::opcode_e                   opcode,
  output logic [4:0]                        rd,
  output logic [4:0]                        rs1,
  output logic [4:0]                        rs2,
  output logic [`RV_XLEN-1:0]               imm,
  output rv_pkg::alu_op_e                   alu_op,
  output logic                              use_imm,
  output logic                              branch_ne,
  output rv_pkg::wb_sel_e                   wb_sel,
  output logic                              reg_we,
  output logic                              mem_we
);

  localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);

  logic [31:0]       imem [`RV_IMEM_WORDS];
  logic [31:0]       instr;
  logic [2:0]        funct3;
  logic              alt;
  rv_pkg::imm_type_e imm_type;

  // program load port, used while the core sits in reset
  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  assign instr  = imem[pc[IMEM_AW+1:2]];
  assign opcode = rv_pkg::opcode_e'(instr[6:0]);
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs2    = instr[24:20];
  // sub, sra and srai are flagged by bit 30
  assign alt    = instr[30];

  // lui has immediate bits in the rs1 field, so read x0 and add
  assign rs1 = (opcode == rv_pkg::op_lui) ? 5'd0 : instr[19:15];

  assign branch_ne = funct3[0];

  always_comb begin
    alu_op   = rv_pkg::alu_add;
    imm_type = rv_pkg::imm_i;
    use_imm  = 1'b0;
    wb_sel   = rv_pkg::wb_alu;
    reg_we   = 1'b0;
    mem_we   = 1'b0;
    case (opcode)
      rv_pkg::op_reg, rv_pkg::op_imm: begin
        use_imm = (opcode == rv_pkg::op_imm);
        reg_we  = 1'b1;
        case (funct3)
          3'b000: begin
            if (opcode == rv_pkg::op_reg && alt) begin
              alu_op = rv_pkg::alu_sub;
            end
          end
          3'b001: alu_op = rv_pkg::alu_sll;
          3'b010: alu_op = rv_pkg::alu_slt;
          3'b100: alu_op = rv_pkg::alu_xor;
          3'b101: alu_op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
          3'b110: alu_op = rv_pkg::alu_or;
          3'b111: alu_op = rv_pkg::alu_and;
          // unsigned compares are not implemented
          default: reg_we = 1'b0;
        endcase
      end
      rv_pkg::op_lui: begin
        imm_type = rv_pkg::imm_u;
        use_imm  = 1'b1;
        reg_we   = 1'b1;
      end
      rv_pkg::op_load: begin
        use_imm = 1'b1;
        wb_sel  = rv_pkg::wb_load;
        reg_we  = 1'b1;
      end
      rv_pkg::op_store: begin
        imm_type = rv_pkg::imm_s;
        use_imm  = 1'b1;
        mem_we   = 1'b1;
      end
      rv_pkg::op_jal: begin
        imm_type = rv_pkg::imm_j;
        wb_sel   = rv_pkg::wb_link;
        reg_we   = 1'b1;
      end
      rv_pkg::op_jalr: begin
        wb_sel = rv_pkg::wb_link;
        reg_we = 1'b1;
      end
      rv_pkg::op_branch: imm_type = rv_pkg::imm_b;
      // anything else runs as a nop
      default: ;
    endcase
  end

  always_comb begin
    case (imm_type)
      rv_pkg::imm_s: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      rv_pkg::imm_b: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
      rv_pkg::imm_u: imm = {instr[31:12], 12'b0};
      rv_pkg::imm_j: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
      default:       imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

  // stores, branches and nops never reach the register file
  assert property (@(posedge clk)
    reg_we |-> opcode inside {rv_pkg::op_reg, rv_pkg::op_imm, rv_pkg::op_lui,
                              rv_pkg::op_load, rv_pkg::op_jal, rv_pkg::op_jalr})
    else $error("reg_we high for opcode %h", opcode);

endmodule

`default_nettype wire

// ==== verilog/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // major opcode, instr[6:0]
  typedef enum logic [6:0] {
    op_load   = 7'b0000011,
    op_imm    = 7'b0010011,
    op_store  = 7'b0100011,
    op_reg    = 7'b0110011,
    op_lui    = 7'b0110111,
    op_branch = 7'b1100011,
    op_jalr   = 7'b1100111,
    op_jal    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt
  } alu_op_e;

  // immediate layouts of the base formats
  typedef enum logic [2:0] {
    imm_i,
    imm_s,
    imm_b,
    imm_u,
    imm_j
  } imm_type_e;

  // source of the register write data
  typedef enum logic [1:0] {
    wb_alu,
    wb_load,
    wb_link
  } wb_sel_e;

endpackage

`default_nettype wire

// ==== verilog/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// datapath and address width
`define RV_XLEN 32

// architectural registers, indexed by 5 bits
`define RV_REG_COUNT 32

// memory depths in 32-bit words
`define RV_IMEM_WORDS 32
`define RV_DMEM_WORDS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif
